// ==== Makefile ====
# Verilator simulation of the vector exponential unit

TOP := tb_exp_vector_unit
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, pass if the log holds the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		-f exp_vector_unit.f --top-module $(TOP) -o $(TOP)
	-./obj_dir/$(TOP) | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== exp_vector_unit.f ====
+incdir+verilog
verilog/exp_pkg.sv
verilog/exp_range_reduce.sv
verilog/exp_lane.sv
verilog/exp_sum_collect.sv
verilog/exp_vector_unit.sv
sim/tb_exp_vector_unit.sv

// ==== sim/tb_exp_vector_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exp_vector_unit;

    import exp_pkg::*;

    `include "exp_table.svh"

    localparam int N_LANES        = 4;
    localparam int VEC_WIDTH      = N_LANES * DATA_WIDTH;
    localparam int LATENCY        = 4;                  // in_valid to out_valid
    localparam int TIMEOUT_CYCLES = 8 + 600 + 20;       // reset + stimulus + margin

    logic                  i_clk = 1'b0;
    logic                  rst_n;
    logic                  in_valid;
    logic [VEC_WIDTH-1:0]  in_args;
    logic                  out_valid;
    logic [VEC_WIDTH-1:0]  out_exps;
    logic [DATA_WIDTH-1:0] out_sum;

    logic [VEC_WIDTH-1:0]  exps_q [$];                  // expected lane words, issue order
    logic [DATA_WIDTH-1:0] sum_q  [$];                  // expected totals
    logic [VEC_WIDTH-1:0]  head_exps  = '0;             // expectation for the current output
    logic [DATA_WIDTH-1:0] head_sum   = '0;
    logic                  head_valid = 1'b0;           // low if nothing was outstanding
    logic                  quiet_check;                 // outputs must stay zero

    int    cycle_count  = 0;
    int    test_errors  = 0;
    int    error_count  = 0;
    int    test_count   = 0;
    int    failed_tests = 0;
    int    vec_count    = 0;
    string test_name    = "none";

    exp_vector_unit #(
        .N_LANES   (N_LANES)
    ) exp_vector_unit_inst (
        .i_clk     (i_clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_args   (in_args),
        .out_valid (out_valid),
        .out_exps  (out_exps),
        .out_sum   (out_sum)
    );

    always #5 i_clk = ~i_clk;                           // 10 ns period

    // run limit
    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    // e^x from the table, straight from the reduction and interpolation rules
    function automatic logic [DATA_WIDTH-1:0] exp_ref(input logic [DATA_WIDTH-1:0] arg);
        logic [INDEX_WIDTH-1:0]           idx;
        logic [STEP_SHIFT-1:0]            frac;
        logic [DATA_WIDTH-1:0]            lo;
        logic [DATA_WIDTH-1:0]            hi;
        logic [DATA_WIDTH+STEP_SHIFT-1:0] prod;
        if (arg >= 32'h0004_0000) begin                 // 4.0 and above
            return EXP_TABLE[TABLE_SIZE-1];
        end
        idx  = INDEX_WIDTH'(arg >> STEP_SHIFT);         // 1/16 steps
        frac = arg[STEP_SHIFT-1:0];
        lo   = EXP_TABLE[idx];
        if (frac == '0) begin
            return lo;                                  // grid point
        end
        hi   = EXP_TABLE[idx + 1];
        prod = (DATA_WIDTH+STEP_SHIFT)'(hi - lo) * (DATA_WIDTH+STEP_SHIFT)'(frac);
        return lo + DATA_WIDTH'(prod >> STEP_SHIFT);
    endfunction

    task automatic count_error();
        error_count++;
        test_errors++;
    endtask

    // drive one vector on the next edge and queue its expectation
    task automatic issue_vector(input logic [VEC_WIDTH-1:0] args);
        logic [VEC_WIDTH-1:0]  exps;
        logic [DATA_WIDTH-1:0] sum;
        sum = '0;
        for (int l = 0; l < N_LANES; l++) begin
            exps[l*DATA_WIDTH +: DATA_WIDTH] = exp_ref(args[l*DATA_WIDTH +: DATA_WIDTH]);
            sum = sum + exps[l*DATA_WIDTH +: DATA_WIDTH];
        end
        @(posedge i_clk);
        in_valid <= 1'b1;
        in_args  <= args;
        exps_q.push_back(exps);
        sum_q.push_back(sum);
        vec_count++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge i_clk);
            in_valid <= 1'b0;
            in_args  <= {$urandom(), $urandom(), $urandom(), $urandom()};  // must be ignored
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        vec_count   = 0;
    endtask

    // drain the pipe, then report this test
    task automatic finish_test();
        idle_cycles(1);
        while (exps_q.size() != 0) begin
            idle_cycles(1);
        end
        idle_cycles(2);                                 // last compare has fired
        test_count++;
        if (test_errors == 0) begin
            $display("PASS %s: %0d vectors", test_name, vec_count);
        end else begin
            failed_tests++;
            $display("FAIL %s: %0d vectors, %0d errors", test_name, vec_count, test_errors);
        end
    endtask

    // expectation for the output that is valid now
    always @(negedge i_clk) begin
        if (out_valid) begin
            head_valid = (exps_q.size() != 0);
            if (exps_q.size() != 0) begin
                head_exps = exps_q.pop_front();
                head_sum  = sum_q.pop_front();
            end
        end
    end

    // quiet outputs in and right after reset
    a_quiet_outputs : assert property (
        @(posedge i_clk) quiet_check |->
            (!out_valid && out_exps == '0 && out_sum == '0)
    ) else begin
        $display("ERROR %s: expected out_valid 0 out_exps 0 out_sum 0, actual %0b %h %h",
                 test_name, $sampled(out_valid), $sampled(out_exps), $sampled(out_sum));
        count_error();
    end

    // fixed latency, one strobe per vector
    a_latency : assert property (
        @(posedge i_clk) disable iff (!rst_n)
        out_valid == $past(in_valid, LATENCY)
    ) else begin
        $display("ERROR %s out_valid latency: expected %0b actual %0b",
                 test_name, !$sampled(out_valid), $sampled(out_valid));
        count_error();
    end

    a_outstanding : assert property (
        @(posedge i_clk) disable iff (!rst_n)
        out_valid |-> head_valid
    ) else begin
        $display("out_valid in %s with no vector outstanding", test_name);
        count_error();
    end

    a_exps : assert property (
        @(posedge i_clk) disable iff (!rst_n)
        (out_valid && head_valid) |-> (out_exps == head_exps)
    ) else begin
        $display("ERROR %s out_exps: expected %h actual %h",
                 test_name, $sampled(head_exps), $sampled(out_exps));
        count_error();
    end

    a_sum : assert property (
        @(posedge i_clk) disable iff (!rst_n)
        (out_valid && head_valid) |-> (out_sum == head_sum)
    ) else begin
        $display("ERROR %s out_sum: expected %h actual %h",
                 test_name, $sampled(head_sum), $sampled(out_sum));
        count_error();
    end

    initial begin
        logic [VEC_WIDTH-1:0] args;
        int                   run_len;
        void'($urandom(32'h4af17775));
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_args     = '0;
        quiet_check = 1'b1;

        // no input through reset and a while after
        start_test("reset_state");
        repeat (8) @(posedge i_clk);
        rst_n <= 1'b1;
        idle_cycles(10);
        quiet_check <= 1'b0;
        finish_test();

        // k/16 for k = 0..63, four per vector
        start_test("grid_points");
        for (int v = 0; v < 16; v++) begin
            for (int l = 0; l < N_LANES; l++) begin
                args[l*DATA_WIDTH +: DATA_WIDTH] = DATA_WIDTH'((v * N_LANES + l) << 12);
            end
            issue_vector(args);
        end
        finish_test();

        // 200 random arguments below 4.0
        start_test("interpolation");
        for (int v = 0; v < 50; v++) begin
            for (int l = 0; l < N_LANES; l++) begin
                args[l*DATA_WIDTH +: DATA_WIDTH] = $urandom() % 32'h0004_0000;
            end
            issue_vector(args);
        end
        finish_test();

        start_test("clamping");
        issue_vector({N_LANES{32'h0004_0000}});         // exactly 4.0
        idle_cycles(1);
        issue_vector({N_LANES{32'h0004_0001}});         // one lsb above
        idle_cycles(1);
        issue_vector({N_LANES{32'hffff_ffff}});
        issue_vector({32'hffff_ffff, 32'h0004_0001, 32'h0004_0000, 32'h0003_ffff});
        finish_test();

        // bursts of back-to-back vectors with idle gaps
        start_test("pipelining");
        for (int r = 0; r < 10; r++) begin
            run_len = 1 + int'($urandom() % 6);
            repeat (run_len) begin
                for (int l = 0; l < N_LANES; l++) begin
                    args[l*DATA_WIDTH +: DATA_WIDTH] = ($urandom() % 5 == 0) ?
                        $urandom() : $urandom() % 32'h0004_0000;  // some clamp
                end
                issue_vector(args);
            end
            idle_cycles(1 + int'($urandom() % 3));
        end
        finish_test();

        $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : tb_exp_vector_unit

`default_nettype wire

// ==== verilog/exp_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module exp_lane (
    input  logic                                i_clk,
    input  logic                                rst_n,
    input  logic                                red_valid,
    input  logic [exp_pkg::INDEX_WIDTH-1:0]     red_index,
    input  logic [exp_pkg::STEP_SHIFT-1:0]      red_frac,
    output logic                                lane_valid,
    output logic [exp_pkg::DATA_WIDTH-1:0]      lane_result
);

    import exp_pkg::*;

    `include "exp_table.svh"

    logic [INDEX_WIDTH-1:0]           ceil_index;  // neighbour entry, pinned at 64
    logic                             s1_valid;    // fetch stage valid
    logic [DATA_WIDTH-1:0]            s1_floor;    // entry at index
    logic [DATA_WIDTH-1:0]            s1_ceil;     // entry at index + 1
    logic [STEP_SHIFT-1:0]            s1_frac;     // fraction carried along
    logic [DATA_WIDTH-1:0]            delta;       // slope over one step
    logic [DATA_WIDTH+STEP_SHIFT-1:0] prod;        // widened slope * frac

    assign ceil_index = (red_index == INDEX_MAX) ? red_index : red_index + 1'b1;

    // stage 1 table fetch
    always_ff @(posedge i_clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_floor <= '0;
            s1_ceil  <= '0;
            s1_frac  <= '0;
        end else begin
            s1_valid <= red_valid;
            if (red_valid) begin
                s1_floor <= EXP_TABLE[red_index];
                s1_ceil  <= EXP_TABLE[ceil_index];
                s1_frac  <= red_frac;
            end
        end
    end

    assign delta = s1_ceil - s1_floor;                 // table is increasing
    assign prod  = delta * s1_frac;                    // no overflow at this width

    // stage 2 multiply-add, frac 0 gives floor exactly
    always_ff @(posedge i_clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_valid  <= 1'b0;
            lane_result <= '0;
        end else begin
            lane_valid <= s1_valid;
            if (s1_valid) begin
                lane_result <= s1_floor + prod[STEP_SHIFT +: DATA_WIDTH];
            end
        end
    end

    // fetched pair is ordered
    a_ceil_ge_floor : assert property (
        @(posedge i_clk) disable iff (!rst_n)
        s1_valid |-> (s1_ceil >= s1_floor)
    ) else $error("ceil entry below floor entry");

    // result stays inside the bracketing pair of the previous stage
    a_result_bounded : assert property (
        @(posedge i_clk) disable iff (!rst_n)
        s1_valid ##1 lane_valid |->
            (lane_result >= $past(s1_floor)) && (lane_result <= $past(s1_ceil))
    ) else $error("interpolated result outside table interval");

endmodule : exp_lane

`default_nettype wire

// ==== verilog/exp_pkg.sv ====
`default_nettype none

package exp_pkg;

    // fixed-point word format, Q16.16
    parameter int DATA_WIDTH = 32;      // argument and result word
    parameter int FRAC_WIDTH = 16;      // fractional bits

    // table geometry
    parameter int STEP_SHIFT  = 12;     // bits below the 1/16 step, also frac width
    parameter int INDEX_WIDTH = 7;      // holds 0..64
    parameter int TABLE_SIZE  = 65;     // entries 0..64

    // saturation point of the argument range
    parameter logic [DATA_WIDTH-1:0] ARG_MAX = 4 << FRAC_WIDTH;  // 4.0

    // index used for clamped arguments
    parameter logic [INDEX_WIDTH-1:0] INDEX_MAX = INDEX_WIDTH'(TABLE_SIZE - 1);

    // vector width when the top level is not overridden
    parameter int N_LANES_DEFAULT = 4;

endpackage : exp_pkg

`default_nettype wire

// ==== verilog/exp_range_reduce.sv ====
`timescale 1ns/1ps
`default_nettype none

module exp_range_reduce #(
    parameter int N_LANES = exp_pkg::N_LANES_DEFAULT
) (
    input  logic                                       i_clk,
    input  logic                                       rst_n,
    input  logic                                       in_valid,
    input  logic [N_LANES*exp_pkg::DATA_WIDTH-1:0]     in_args,
    output logic                                       red_valid,
    output logic [N_LANES*exp_pkg::INDEX_WIDTH-1:0]    red_index,
    output logic [N_LANES*exp_pkg::STEP_SHIFT-1:0]     red_frac
);

    import exp_pkg::*;

    logic [N_LANES*INDEX_WIDTH-1:0] index_next;    // per-lane table index
    logic [N_LANES*STEP_SHIFT-1:0]  frac_next;     // per-lane interpolation fraction

    // split each argument into index and fraction
    always_comb begin
        logic [DATA_WIDTH-1:0] arg;
        for (int l = 0; l < N_LANES; l++) begin
            arg = in_args[l*DATA_WIDTH +: DATA_WIDTH];
            if (arg >= ARG_MAX) begin                          // saturate at e^4
                index_next[l*INDEX_WIDTH +: INDEX_WIDTH] = INDEX_MAX;
                frac_next[l*STEP_SHIFT +: STEP_SHIFT]    = '0;
            end else begin
                index_next[l*INDEX_WIDTH +: INDEX_WIDTH] =
                    arg[STEP_SHIFT +: INDEX_WIDTH];            // bits above the step
                frac_next[l*STEP_SHIFT +: STEP_SHIFT]    =
                    arg[STEP_SHIFT-1:0];                       // position inside the step
            end
        end
    end

    // one register stage for all lanes
    always_ff @(posedge i_clk or negedge rst_n) begin
        if (!rst_n) begin
            red_valid <= 1'b0;
            red_index <= '0;
            red_frac  <= '0;
        end else begin
            red_valid <= in_valid;                             // strobe follows data by 1
            if (in_valid) begin                                // sample only on strobe
                red_index <= index_next;
                red_frac  <= frac_next;
            end
        end
    end

    // index never points past the last table entry
    for (genvar g = 0; g < N_LANES; g++) begin : g_chk
        a_index_range : assert property (
            @(posedge i_clk) disable iff (!rst_n)
            red_valid |-> (red_index[g*INDEX_WIDTH +: INDEX_WIDTH] <= INDEX_MAX)
        ) else $error("lane %0d index out of table range", g);
    end

endmodule : exp_range_reduce

`default_nettype wire

// ==== verilog/exp_sum_collect.sv ====
`timescale 1ns/1ps
`default_nettype none

module exp_sum_collect #(
    parameter int N_LANES = exp_pkg::N_LANES_DEFAULT
) (
    input  logic                                    i_clk,
    input  logic                                    rst_n,
    input  logic [N_LANES-1:0]                      lane_valid,
    input  logic [N_LANES*exp_pkg::DATA_WIDTH-1:0]  lane_results,
    output logic                                    out_valid,
    output logic [N_LANES*exp_pkg::DATA_WIDTH-1:0]  out_exps,
    output logic [exp_pkg::DATA_WIDTH-1:0]          out_sum
);

    import exp_pkg::*;

    logic                  vec_valid;  // lanes move in lockstep
    logic [DATA_WIDTH-1:0] sum_next;   // combinational lane total

    assign vec_valid = lane_valid[0];

    // adder loop over the lanes
    always_comb begin
        sum_next = '0;
        for (int l = 0; l < N_LANES; l++) begin
            sum_next = sum_next + lane_results[l*DATA_WIDTH +: DATA_WIDTH];  // fits for <= 64 lanes
        end
    end

    // output registers, held until the next vector
    always_ff @(posedge i_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_exps  <= '0;
            out_sum   <= '0;
        end else begin
            out_valid <= vec_valid;            // one-cycle strobe
            if (vec_valid) begin
                out_exps <= lane_results;
                out_sum  <= sum_next;
            end
        end
    end

    // all lanes share one reducer strobe and the same depth
    a_lanes_aligned : assert property (
        @(posedge i_clk) disable iff (!rst_n)
        (&lane_valid) == (|lane_valid)
    ) else $error("lane valid bits disagree: %b", lane_valid);

endmodule : exp_sum_collect

`default_nettype wire

// ==== verilog/exp_table.svh ====
// e^(k/16) in Q16.16, k = 0..64, rounded to nearest
localparam logic [exp_pkg::DATA_WIDTH-1:0] EXP_TABLE [0:exp_pkg::TABLE_SIZE-1] = '{
    32'd65536,      // e^0.0000
    32'd69763,
    32'd74262,
    32'd79052,
    32'd84150,      // e^0.25
    32'd89577,
    32'd95354,
    32'd101504,
    32'd108051,     // e^0.5
    32'd115019,
    32'd122437,
    32'd130334,
    32'd138740,     // e^0.75
    32'd147688,
    32'd157213,
    32'd167352,
    32'd178145,     // e^1
    32'd189635,
    32'd201865,
    32'd214884,
    32'd228743,     // e^1.25
    32'd243496,
    32'd259200,
    32'd275917,
    32'd293712,     // e^1.5
    32'd312655,
    32'd332819,
    32'd354284,
    32'd377134,     // e^1.75
    32'd401457,
    32'd427348,
    32'd454910,
    32'd484249,     // e^2
    32'd515481,
    32'd548726,
    32'd584116,
    32'd621788,     // e^2.25
    32'd661890,
    32'd704578,
    32'd750020,
    32'd798392,     // e^2.5
    32'd849884,
    32'd904697,
    32'd963044,
    32'd1025156,    // e^2.75
    32'd1091272,
    32'd1161653,
    32'd1236574,
    32'd1316326,    // e^3
    32'd1401221,
    32'd1491592,
    32'd1587792,
    32'd1690196,    // e^3.25
    32'd1799204,
    32'd1915243,
    32'd2038765,
    32'd2170254,    // e^3.5
    32'd2310224,
    32'd2459220,
    32'd2617826,
    32'd2786662,    // e^3.75
    32'd2966386,
    32'd3157701,
    32'd3361356,
    32'd3578144     // e^4, clamp value
};

// ==== verilog/exp_vector_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exp_vector_unit #(
    parameter int N_LANES = exp_pkg::N_LANES_DEFAULT
) (
    input  logic                                    i_clk,
    input  logic                                    rst_n,
    input  logic                                    in_valid,
    input  logic [N_LANES*exp_pkg::DATA_WIDTH-1:0]  in_args,
    output logic                                    out_valid,
    output logic [N_LANES*exp_pkg::DATA_WIDTH-1:0]  out_exps,
    output logic [exp_pkg::DATA_WIDTH-1:0]          out_sum
);

    import exp_pkg::*;

    logic                           red_valid;     // shared reducer strobe
    logic [N_LANES*INDEX_WIDTH-1:0] red_index;     // packed per-lane index
    logic [N_LANES*STEP_SHIFT-1:0]  red_frac;      // packed per-lane fraction
    logic [N_LANES-1:0]             lane_valid;    // one bit per lane
    logic [N_LANES*DATA_WIDTH-1:0]  lane_results;  // packed lane words

    // clamp and split, 1 cycle
    exp_range_reduce #(
        .N_LANES   (N_LANES)
    ) exp_range_reduce_inst (
        .i_clk     (i_clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_args   (in_args),
        .red_valid (red_valid),
        .red_index (red_index),
        .red_frac  (red_frac)
    );

    // table interpolation, 2 cycles per lane
    for (genvar g = 0; g < N_LANES; g++) begin : g_lane
        exp_lane exp_lane_inst (
            .i_clk       (i_clk),
            .rst_n       (rst_n),
            .red_valid   (red_valid),
            .red_index   (red_index[g*INDEX_WIDTH +: INDEX_WIDTH]),
            .red_frac    (red_frac[g*STEP_SHIFT +: STEP_SHIFT]),
            .lane_valid  (lane_valid[g]),
            .lane_result (lane_results[g*DATA_WIDTH +: DATA_WIDTH])
        );
    end

    // register words and total, 1 cycle
    exp_sum_collect #(
        .N_LANES      (N_LANES)
    ) exp_sum_collect_inst (
        .i_clk        (i_clk),
        .rst_n        (rst_n),
        .lane_valid   (lane_valid),
        .lane_results (lane_results),
        .out_valid    (out_valid),
        .out_exps     (out_exps),
        .out_sum      (out_sum)
    );

endmodule : exp_vector_unit

`default_nettype wire
